// File: all.f
pe_width_pkg.sv
pe_ctrl_pkg.sv
signed_mult_pipe.sv
packed_lane_mac.sv
operand_port.sv
mac_sequencer.sv
packed_mac_top.sv
tb_packed_mac.sv

// File: mac_sequencer.sv
`default_nettype none

module mac_sequencer #(
  parameter int HEADROOM = 6
) (
  input  logic clk,
  input  logic reset,
  input  logic issue,
  input  logic issue_last,
  input  logic res_ack,
  input  logic [pe_width_pkg::LANES*(pe_width_pkg::SLOT_W+HEADROOM)-1:0] lanes,
  output logic accept,
  output logic clear,
  output logic res_req,
  output logic [pe_width_pkg::LANES*(pe_width_pkg::SLOT_W+HEADROOM)-1:0] res_lanes
);

  // Multiplier latency plus the lane update cycle
  localparam int DRAIN_CYCLES = pe_ctrl_pkg::MULT_STAGES + 1;
  localparam int CNT_W        = $clog2(DRAIN_CYCLES + 1);

  typedef logic [CNT_W-1:0] drain_cnt_t;

  pe_ctrl_pkg::job_state_t state;
  drain_cnt_t              drain_cnt;
  logic                    drain_done;

  assign drain_done = (state == pe_ctrl_pkg::job_drain) &&
                      (drain_cnt == drain_cnt_t'(DRAIN_CYCLES - 1));

  // Intake is open only while accumulating
  assign accept = (state == pe_ctrl_pkg::job_accum);
  assign clear  = (state == pe_ctrl_pkg::job_clear);

  //////////////////////////////////////////////////
  // Job FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= pe_ctrl_pkg::job_accum;
      drain_cnt <= '0;
      res_req   <= 1'b0;
    end else begin
      case (state)
        pe_ctrl_pkg::job_accum: begin
          if (issue && issue_last) begin
            state     <= pe_ctrl_pkg::job_drain;
            drain_cnt <= '0;
          end
        end
        pe_ctrl_pkg::job_drain: begin
          if (drain_done) begin
            state   <= pe_ctrl_pkg::job_present;
            res_req <= 1'b1;
          end else begin
            drain_cnt <= drain_cnt + drain_cnt_t'(1);
          end
        end
        // Result handshake drops req once ack is seen
        pe_ctrl_pkg::job_present: begin
          if (res_ack) begin
            state   <= pe_ctrl_pkg::job_release;
            res_req <= 1'b0;
          end
        end
        pe_ctrl_pkg::job_release: begin
          if (!res_ack) state <= pe_ctrl_pkg::job_clear;
        end
        // Lanes zero on the edge that leaves this state
        pe_ctrl_pkg::job_clear: state <= pe_ctrl_pkg::job_accum;
        default: state <= pe_ctrl_pkg::job_accum;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Result snapshot
  //////////////////////////////////////////////////

  // Last sum has landed by the end of the drain
  always_ff @(posedge clk) begin
    if (drain_done) begin
      res_lanes <= lanes;
    end
  end

endmodule

`default_nettype wire

// File: operand_port.sv
`default_nettype none

module operand_port (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       accept,
  input  logic                       op_req,
  input  logic                       op_last,
  input  pe_width_pkg::pixel_word_t  op_pixel,
  input  pe_width_pkg::weight_word_t op_weight,
  output logic                       op_ack,
  output logic                       issue,
  output logic                       issue_last,
  output pe_width_pkg::pixel_word_t  pixel,
  output pe_width_pkg::weight_word_t weight
);

  pe_ctrl_pkg::port_state_t state;
  logic                     capture;

  // Request is only taken while the sequencer opens intake
  assign capture = (state == pe_ctrl_pkg::port_idle) && accept && op_req;

  // Ack follows the hold state, so it rises with issue
  assign op_ack = (state == pe_ctrl_pkg::port_hold);

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= pe_ctrl_pkg::port_idle;
      issue      <= 1'b0;
      issue_last <= 1'b0;
    end else begin
      issue      <= capture;
      issue_last <= capture && op_last;
      case (state)
        pe_ctrl_pkg::port_idle: begin
          if (capture) state <= pe_ctrl_pkg::port_hold;
        end
        pe_ctrl_pkg::port_hold: begin
          if (!op_req) state <= pe_ctrl_pkg::port_release;
        end
        // One quiet cycle with ack low before the next request
        pe_ctrl_pkg::port_release: state <= pe_ctrl_pkg::port_idle;
        default: state <= pe_ctrl_pkg::port_idle;
      endcase
    end
  end

  // Holding registers for the operand pair
  always_ff @(posedge clk) begin
    if (capture) begin
      pixel  <= op_pixel;
      weight <= op_weight;
    end
  end

endmodule

`default_nettype wire

// File: packed_lane_mac.sv
`default_nettype none

module packed_lane_mac #(
  parameter int HEADROOM = 6
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   clear,
  input  logic                   product_valid,
  input  pe_width_pkg::product_t product,
  output logic [pe_width_pkg::LANES*(pe_width_pkg::SLOT_W+HEADROOM)-1:0] lanes
);

  localparam int SW     = pe_width_pkg::SLOT_W;
  localparam int LANE_W = SW + HEADROOM;

  typedef logic [LANE_W-1:0] lane_t;

  lane_t lane_q   [pe_width_pkg::LANES];
  lane_t lane_inc [pe_width_pkg::LANES];

  //////////////////////////////////////////////////
  // Slot extraction and borrow correction
  //////////////////////////////////////////////////

  // A negative slot below borrows one from the slot above it, so the top
  // bit of slot k-1 is added back into lane k. Product bit 32 lies above
  // the last slot and carries no lane
  for (genvar k = 0; k < pe_width_pkg::LANES; k++) begin : g_lane
    lane_t slot_ext;
    lane_t borrow;

    assign slot_ext = {{HEADROOM{product[SW*k+SW-1]}}, product[SW*k +: SW]};

    if (k == 0) begin : g_first
      assign borrow = '0;
    end else begin : g_upper
      assign borrow = lane_t'(product[SW*k-1]);
    end

    assign lane_inc[k] = slot_ext + borrow;

    assign lanes[LANE_W*k +: LANE_W] = lane_q[k];
  end

  //////////////////////////////////////////////////
  // Lane accumulators
  //////////////////////////////////////////////////

  // Lanes wrap modulo 2**LANE_W
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      for (int k = 0; k < pe_width_pkg::LANES; k++) begin
        lane_q[k] <= '0;
      end
    end else if (product_valid) begin
      for (int k = 0; k < pe_width_pkg::LANES; k++) begin
        lane_q[k] <= lane_q[k] + lane_inc[k];
      end
    end
  end

endmodule

`default_nettype wire

// File: packed_mac_top.sv
`default_nettype none

module packed_mac_top #(
  parameter int HEADROOM = 6
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       op_req,
  input  logic                       op_last,
  input  pe_width_pkg::pixel_word_t  op_pixel,
  input  pe_width_pkg::weight_word_t op_weight,
  output logic                       op_ack,
  output logic                       res_req,
  input  logic                       res_ack,
  output logic [pe_width_pkg::LANES*(pe_width_pkg::SLOT_W+HEADROOM)-1:0] res_lanes
);

  localparam int VEC_W = pe_width_pkg::LANES * (pe_width_pkg::SLOT_W + HEADROOM);

  logic                       accept;
  logic                       issue;
  logic                       issue_last;
  logic                       clear;
  logic                       product_valid;
  pe_width_pkg::pixel_word_t  pixel;
  pe_width_pkg::weight_word_t weight;
  pe_width_pkg::product_t     product;
  logic [VEC_W-1:0]           lanes;

  operand_port u_port (
    .clk        (clk),
    .reset      (reset),
    .accept     (accept),
    .op_req     (op_req),
    .op_last    (op_last),
    .op_pixel   (op_pixel),
    .op_weight  (op_weight),
    .op_ack     (op_ack),
    .issue      (issue),
    .issue_last (issue_last),
    .pixel      (pixel),
    .weight     (weight)
  );

  signed_mult_pipe u_mult (
    .clk           (clk),
    .reset         (reset),
    .in_valid      (issue),
    .pixel         (pixel),
    .weight        (weight),
    .product       (product),
    .product_valid (product_valid)
  );

  packed_lane_mac #(
    .HEADROOM (HEADROOM)
  ) u_lane_mac (
    .clk           (clk),
    .reset         (reset),
    .clear         (clear),
    .product_valid (product_valid),
    .product       (product),
    .lanes         (lanes)
  );

  mac_sequencer #(
    .HEADROOM (HEADROOM)
  ) u_seq (
    .clk        (clk),
    .reset      (reset),
    .issue      (issue),
    .issue_last (issue_last),
    .res_ack    (res_ack),
    .lanes      (lanes),
    .accept     (accept),
    .clear      (clear),
    .res_req    (res_req),
    .res_lanes  (res_lanes)
  );

endmodule

`default_nettype wire

// File: pe_ctrl_pkg.sv
`default_nettype none

package pe_ctrl_pkg;

  // Cycles from operand issue to product valid
  localparam int MULT_STAGES = 2;

  // Four-phase operand receiver
  typedef enum logic [1:0] {
    port_idle,
    port_hold,
    port_release
  } port_state_t;

  // Job sequencer
  typedef enum logic [2:0] {
    job_accum,
    job_drain,
    job_present,
    job_release,
    job_clear
  } job_state_t;

endpackage

`default_nettype wire

// File: pe_width_pkg.sv
`default_nettype none

package pe_width_pkg;

  //////////////////////////////////////////////////
  // Operand and product widths
  //////////////////////////////////////////////////

  // Packed operand words as they come from the packer
  localparam int PIXEL_W   = 21;
  localparam int WEIGHT_W  = 12;

  // Full signed product of the two packed words
  localparam int PRODUCT_W = 33;

  // Product is read as sixteen 2-bit slots
  localparam int LANES     = 16;
  localparam int SLOT_W    = 2;

  typedef logic [PIXEL_W-1:0]   pixel_word_t;
  typedef logic [WEIGHT_W-1:0]  weight_word_t;
  typedef logic [PRODUCT_W-1:0] product_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the packed MAC testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 --top-module tb_packed_mac -f all.f; then
  echo "Verilator build failed"
  exit 1
fi

if ! sim_out=$(./obj_dir/Vtb_packed_mac); then
  echo "$sim_out"
  echo "Simulation exited with an error"
  exit 1
fi
echo "$sim_out"

if echo "$sim_out" | grep -qx "No errors"; then
  exit 0
fi
exit 1

// File: signed_mult_pipe.sv
`default_nettype none

// Behavioral stand-in for the DSP multiplier core, with input and
// output registers. Latency matches pe_ctrl_pkg::MULT_STAGES (2)
module signed_mult_pipe (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       in_valid,
  input  pe_width_pkg::pixel_word_t  pixel,
  input  pe_width_pkg::weight_word_t weight,
  output pe_width_pkg::product_t     product,
  output logic                       product_valid
);

  localparam int PIX_PAD = pe_width_pkg::PRODUCT_W - pe_width_pkg::PIXEL_W;
  localparam int WGT_PAD = pe_width_pkg::PRODUCT_W - pe_width_pkg::WEIGHT_W;

  pe_width_pkg::pixel_word_t  pixel_q;
  pe_width_pkg::weight_word_t weight_q;
  logic                       valid_q;
  pe_width_pkg::product_t     pixel_ext;
  pe_width_pkg::product_t     weight_ext;

  // Valid bits walk alongside the data
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q       <= 1'b0;
      product_valid <= 1'b0;
    end else begin
      valid_q       <= in_valid;
      product_valid <= valid_q;
    end
  end

  // Sign-extend both operands to the product width
  assign pixel_ext  = {{PIX_PAD{pixel_q[pe_width_pkg::PIXEL_W-1]}}, pixel_q};
  assign weight_ext = {{WGT_PAD{weight_q[pe_width_pkg::WEIGHT_W-1]}}, weight_q};

  // Input register, then signed multiply into the output register
  always_ff @(posedge clk) begin
    pixel_q  <= pixel;
    weight_q <= weight;
    product  <= $signed(pixel_ext) * $signed(weight_ext);
  end

endmodule

`default_nettype wire

// File: tb_packed_mac.sv
`default_nettype none

module tb_packed_mac;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int HEADROOM    = 6;
  localparam int LANE_W      = pe_width_pkg::SLOT_W + HEADROOM;
  localparam int VEC_W       = pe_width_pkg::LANES * LANE_W;
  localparam int N_JOBS      = 6;
  localparam int N_PAIRS     = 1 + 4 + 40 + 72 + 3 + 2;
  localparam int CYCLE_LIMIT = 40 * N_PAIRS + 200;

  typedef logic [VEC_W-1:0] lane_vec_t;

  logic                       clk;
  logic                       reset;
  logic                       op_req;
  logic                       op_last;
  pe_width_pkg::pixel_word_t  op_pixel;
  pe_width_pkg::weight_word_t op_weight;
  logic                       op_ack;
  logic                       res_req;
  logic                       res_ack;
  lane_vec_t                  res_lanes;

  pe_width_pkg::pixel_word_t  job_pix[$];
  pe_width_pkg::weight_word_t job_wgt[$];
  lane_vec_t                  exp_q[$];
  lane_vec_t                  held_lanes;
  logic [31:0]                lcg_state = 32'd24;
  int                         error_count = 0;
  int                         check_count = 0;
  int                         cyc = 0;
  int                         last_ack_cyc = 0;
  int                         closed_jobs = 0;
  int                         sink_delay [N_JOBS] = '{0, 2, 1, 5, 9, 3};
  logic                       res_req_prev = 1'b0;
  logic                       res_ack_prev = 1'b0;
  logic                       op_ack_prev = 1'b0;
  logic                       op_req_prev = 1'b0;
  logic                       result_busy = 1'b0;

  packed_mac_top #(.HEADROOM(HEADROOM)) DUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Reference model and stimulus helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Lane sums kept as plain integers, wrapped to the lane width at the end
  function automatic lane_vec_t expected_lanes(input pe_width_pkg::pixel_word_t pix[$],
                                               input pe_width_pkg::weight_word_t wgt[$]);
    longint    prod;
    int        slot;
    int        below_top;
    int        sum [pe_width_pkg::LANES];
    lane_vec_t res;
    sum = '{default: 0};
    for (int i = 0; i < pix.size(); i++) begin
      prod      = longint'($signed(pix[i])) * longint'($signed(wgt[i]));
      below_top = 0;
      for (int k = 0; k < pe_width_pkg::LANES; k++) begin
        // Signed 2-bit slot, plus top bit of the slot below
        slot = int'(prod[2*k +: 2]);
        if (slot > 1) begin
          slot = slot - 4;
        end
        sum[k]    = sum[k] + slot + below_top;
        below_top = int'(prod[2*k+1]);
      end
    end
    for (int k = 0; k < pe_width_pkg::LANES; k++) begin
      res[LANE_W*k +: LANE_W] = sum[k][LANE_W-1:0];
    end
    return res;
  endfunction

  task automatic check_value(input string name, input lane_vec_t got, input lane_vec_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Fail %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_error(input string what);
    error_count++;
    $display("Error: %s", what);
  endtask

  task automatic wait_drive_slot();
    @(posedge clk);
    #10;
  endtask

  task automatic send_pair(input pe_width_pkg::pixel_word_t pix,
                           input pe_width_pkg::weight_word_t wgt, input logic last);
    wait_drive_slot();
    op_pixel  = pix;
    op_weight = wgt;
    op_last   = last;
    op_req    = 1'b1;
    while (!op_ack) wait_drive_slot();
    op_req = 1'b0;
    while (op_ack) wait_drive_slot();
  endtask

  task automatic answer_result(input int delay);
    wait_drive_slot();
    while (!res_req) wait_drive_slot();
    repeat (delay) wait_drive_slot();
    res_ack = 1'b1;
    while (res_req) wait_drive_slot();
    res_ack = 1'b0;
  endtask

  task automatic add_pair(input int p, input int w);
    job_pix.push_back(p[pe_width_pkg::PIXEL_W-1:0]);
    job_wgt.push_back(w[pe_width_pkg::WEIGHT_W-1:0]);
  endtask

  // Wrap mode pins pixel bits 1:0 to 10 and makes the weight odd,
  // so lane 0 steps by -2 on every pair
  task automatic add_random_pair(input logic wrap);
    logic [31:0] a;
    logic [31:0] b;
    a = lcg_next();
    b = lcg_next();
    if (wrap) begin
      a[9:8] = 2'b10;
      b[16]  = 1'b1;
    end
    job_pix.push_back(a[28:8]);
    job_wgt.push_back(b[27:16]);
  endtask

  task automatic send_job();
    exp_q.push_back(expected_lanes(job_pix, job_wgt));
    foreach (job_pix[i]) begin
      send_pair(job_pix[i], job_wgt[i], i == job_pix.size() - 1);
    end
    job_pix.delete();
    job_wgt.delete();
  endtask

  //////////////////////////////////////////////////
  // Result compare and protocol monitor
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!reset) begin
      if (res_req && !res_req_prev) begin
        if (exp_q.size() == 0) begin
          report_error("result request with no job outstanding");
        end else begin
          check_value("res_lanes", res_lanes, exp_q.pop_front());
        end
        check_value("res_req latency", lane_vec_t'(cyc - last_ack_cyc),
                    lane_vec_t'(pe_ctrl_pkg::MULT_STAGES + 2));
      end
      if (res_req && res_req_prev) begin
        check_value("res_lanes hold", res_lanes, held_lanes);
      end
      if (res_req_prev && !res_req && !res_ack_prev) begin
        report_error("res_req dropped before res_ack was raised");
      end
      // Ack must drop on the edge after the request falls
      if (op_ack && op_ack_prev && !op_req_prev) begin
        report_error("op_ack still high a cycle after op_req fell");
      end
      // Intake must stay shut from the last pair until res_ack falls
      if (op_ack && !op_ack_prev) begin
        if (result_busy) begin
          report_error("op_ack raised while a result was still pending");
        end
        if (op_last) begin
          result_busy  = 1'b1;
          last_ack_cyc = cyc;
        end
      end
      if (res_ack_prev && !res_ack) begin
        result_busy = 1'b0;
      end
    end
    held_lanes   = res_lanes;
    res_req_prev = res_req;
    res_ack_prev = res_ack;
    op_ack_prev  = op_ack;
    op_req_prev  = op_req;
  end

  initial begin
    for (int j = 0; j < N_JOBS; j++) begin
      answer_result(sink_delay[j]);
      closed_jobs++;
    end
  end

  initial begin
    while (cyc < CYCLE_LIMIT) begin
      @(posedge clk);
      cyc++;
    end
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Checks: %0d  errors: %0d", check_count, error_count + 1);
    $display("Errors found");
    $finish;
  end

  initial begin
    reset     = 1'b1;
    op_req    = 1'b0;
    op_last   = 1'b0;
    op_pixel  = '0;
    op_weight = '0;
    res_ack   = 1'b0;
    repeat (4) @(posedge clk);
    #10;
    reset = 1'b0;
    add_pair(5, 3);
    send_job();
    // Negative operands that set borrow bits across the slots
    add_pair(-1, 1);
    add_pair(-3, 7);
    add_pair(12345, -2);
    add_pair(-100000, -2047);
    send_job();
    repeat (40) add_random_pair(1'b0);
    send_job();
    repeat (72) add_random_pair(1'b1);
    send_job();
    // First pair here is raised while the previous job drains
    repeat (3) add_random_pair(1'b0);
    send_job();
    add_pair(-1048576, -2048);
    add_pair(7, 9);
    send_job();
    wait (closed_jobs == N_JOBS);
    repeat (4) @(posedge clk);
    if (exp_q.size() != 0) begin
      report_error("results missing at end of run");
    end
    $display("Checks: %0d  errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
